//--- lsu_fifo.sv
// synchronous circular queue with a count register
// payload type given as a type parameter
module lsu_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output logic     head_valid_o,
    output payload_t head_o,
    output logic     full_o
);

    payload_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH + 1)-1:0] count;
    logic                         do_push;
    logic                         do_pop;

    assign head_valid_o = (count != '0);
    assign full_o       = (count == $bits(count)'(DEPTH));
    assign head_o       = mem[rd_ptr];

    // a push into a full queue is taken only when the head leaves that cycle
    assign do_push = push_i && (!full_o || pop_i);
    assign do_pop  = pop_i && head_valid_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // simultaneous push and pop keeps the count
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- lsu_issue.sv
// issue logic driving AR or AW/W from the request queue head,
// pushing load tracking entries and counting stores awaiting a response
module lsu_issue (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                head_valid_i,
    input  lsu_pkg::lsu_req_t                   head_i,
    output logic                                pop_o,
    input  logic                                trk_full_i,
    output logic                                trk_push_o,
    output lsu_pkg::lsu_trk_t                   trk_o,
    output logic                                ar_valid_o,
    output lsu_pkg::axi_ar_t                    ar_o,
    input  logic                                ar_ready_i,
    output logic                                aw_valid_o,
    output logic                                w_valid_o,
    output lsu_pkg::axi_w_t                     w_o,
    input  logic                                aw_ready_i,
    input  logic                                w_ready_i,
    input  logic                                b_valid_i,
    output logic [lsu_pkg::STORE_CNT_W-1:0]     stores_pending_o
);
    import lsu_pkg::*;

    logic is_store;
    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic aw_done;
    logic w_done;
    logic store_pop;

    assign is_store = (head_i.op == LSU_SW);

    // loads wait here while every tracking slot is taken
    assign ar_valid_o = head_valid_i && !is_store && !trk_full_i;
    assign ar_o.addr  = head_i.addr;
    assign ar_hs      = ar_valid_o && ar_ready_i;

    // each write channel offered once per store
    assign aw_valid_o = head_valid_i && is_store && !aw_done;
    assign w_valid_o  = head_valid_i && is_store && !w_done;
    assign w_o.addr   = head_i.addr;
    assign w_o.data   = head_i.wdata;
    assign w_o.strb   = head_i.wstrb;
    assign aw_hs      = aw_valid_o && aw_ready_i;
    assign w_hs       = w_valid_o && w_ready_i;

    assign store_pop = head_valid_i && is_store && (aw_done || aw_hs) && (w_done || w_hs);
    assign pop_o     = ar_hs || store_pop;

    assign trk_push_o      = ar_hs;
    assign trk_o.op        = head_i.op;
    assign trk_o.offset    = head_i.addr[1:0];
    assign trk_o.rd        = head_i.rd;
    assign trk_o.commit_id = head_i.commit_id;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (store_pop) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_done <= 1'b1;
            end
            if (w_hs) begin
                w_done <= 1'b1;
            end
        end
    end

    // outstanding write responses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stores_pending_o <= '0;
        end else begin
            case ({store_pop, b_valid_i})
                2'b10:   stores_pending_o <= stores_pending_o + 1'b1;
                2'b01:   stores_pending_o <= stores_pending_o - 1'b1;
                default: stores_pending_o <= stores_pending_o;
            endcase
        end
    end

endmodule

//--- lsu_load_align.sv
// read beat aligner with lane select, sign or zero extension,
// register write-back and tracking queue pop
module lsu_load_align (
    input  logic                          trk_valid_i,
    input  lsu_pkg::lsu_trk_t             trk_i,
    input  logic                          r_valid_i,
    input  logic [lsu_pkg::DATA_W-1:0]    r_data_i,
    output logic                          trk_pop_o,
    output lsu_pkg::lsu_wb_t              wb_o
);
    import lsu_pkg::*;

    logic [7:0]          byte_lane;
    logic [15:0]         half_lane;
    logic [DATA_W-1:0]   ext_data;

    // a stray beat with nothing tracked writes nothing back
    assign trk_pop_o = r_valid_i && trk_valid_i;

    // a byte at offset 0..3 and a halfword picked by address bit 1
    assign byte_lane = r_data_i[{trk_i.offset, 3'b000} +: 8];
    assign half_lane = trk_i.offset[1] ? r_data_i[DATA_W-1:DATA_W/2]
                                       : r_data_i[DATA_W/2-1:0];

    always_comb begin
        case (trk_i.op)
            LSU_LB:  ext_data = {{(DATA_W - 8){byte_lane[7]}}, byte_lane};
            LSU_LBU: ext_data = {{(DATA_W - 8){1'b0}}, byte_lane};
            LSU_LH:  ext_data = {{(DATA_W - 16){half_lane[15]}}, half_lane};
            LSU_LHU: ext_data = {{(DATA_W - 16){1'b0}}, half_lane};
            // full word
            default: ext_data = r_data_i;
        endcase
    end

    always_comb begin
        wb_o.valid     = trk_pop_o;
        wb_o.rd        = trk_i.rd;
        wb_o.data      = ext_data;
        wb_o.commit_id = trk_i.commit_id;
    end

endmodule

//--- lsu_pkg.sv
// load/store unit package with widths, queue depths and the operation enum
// plus request, tracking, write-back and reduced bus payload structs
package lsu_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;
    localparam int REG_ADDR_W  = 5;
    localparam int COMMIT_ID_W = 3;

    // the tracking depth also bounds the loads in flight
    localparam int REQ_DEPTH = 4;
    localparam int TRK_DEPTH = 4;

    // stores accepted on the bus but still waiting for b_valid
    localparam int STORE_CNT_W = 4;

    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SW  = 3'd5
    } lsu_op_e;

    // one request from execute
    typedef struct packed {
        lsu_op_e                op;
        logic [ADDR_W-1:0]      addr;
        logic [DATA_W-1:0]      wdata;
        logic [STRB_W-1:0]      wstrb;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } lsu_req_t;

    // one load waiting for its read beat
    typedef struct packed {
        lsu_op_e                  op;
        logic [$clog2(STRB_W)-1:0] offset;
        logic [REG_ADDR_W-1:0]    rd;
        logic [COMMIT_ID_W-1:0]   commit_id;
    } lsu_trk_t;

    typedef struct packed {
        logic                   valid;
        logic [REG_ADDR_W-1:0]  rd;
        logic [DATA_W-1:0]      data;
        logic [COMMIT_ID_W-1:0] commit_id;
    } lsu_wb_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } axi_ar_t;

    // aw and w leave from the same queue head, so address rides with data
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } axi_w_t;

endpackage

//--- lsu_stimulus.txt
// op addr wdata wstrb rd commit_id expected, all hex
// op 0-5 lb lh lw lbu lhu sw; 6 holds ar_ready low; 7 presets a memory word; f ends
7 00000000 80f17f23 0 00 0 00000000
7 00000004 1234a5c6 0 00 0 00000000
7 00000008 00000000 0 00 0 00000000
0 00000000 00000000 0 01 0 00000023
0 00000001 00000000 0 02 1 0000007f
0 00000002 00000000 0 03 2 fffffff1
0 00000003 00000000 0 04 3 ffffff80
3 00000002 00000000 0 05 4 000000f1
1 00000004 00000000 0 06 5 ffffa5c6
1 00000006 00000000 0 07 6 00001234
4 00000004 00000000 0 08 7 0000a5c6
5 00000008 deadbeef 6 00 0 00000000
2 00000008 00000000 0 09 1 00adbe00
6 00000000 00000000 0 00 0 00000000
3 00000003 00000000 0 0a 2 00000080
4 00000002 00000000 0 0b 3 000080f1
2 00000000 00000000 0 0c 4 80f17f23
1 0000000a 00000000 0 0d 5 000000ad
0 00000009 00000000 0 0e 6 ffffffbe
f 00000000 00000000 0 00 0 00000000

//--- lsu_sva.sv
// bound checks on AR and W hold rules, stall after reset
// and write-back timing against read beats
module lsu_sva (
    input logic             clk,
    input logic             rst_n,
    input logic             ar_valid_o,
    input lsu_pkg::axi_ar_t ar_o,
    input logic             ar_ready_i,
    input logic             w_valid_o,
    input lsu_pkg::axi_w_t  w_o,
    input logic             w_ready_i,
    input logic             stall_o,
    input logic             r_valid_i,
    input lsu_pkg::lsu_wb_t wb_o
);

    int unsigned fail_count = 0;

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
        else begin
            fail_count++;
            $error("AR valid or address changed before ready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
        else begin
            fail_count++;
            $error("W valid or payload changed before ready");
        end

    stall_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !stall_o)
        else begin
            fail_count++;
            $error("stall_o high on reset release");
        end

    // every beat from the slave belongs to a tracked load and writes back at once
    wb_with_beat: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.valid == r_valid_i)
        else begin
            fail_count++;
            $error("write-back and read beat out of step");
        end

endmodule

//--- lsu_top.sv
// load/store unit top with the request queue, issue logic,
// load tracking queue and read data aligner
module lsu_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid_i,
    input  lsu_pkg::lsu_req_t             req_i,
    output logic                          stall_o,
    output logic                          busy_o,
    output logic                          ar_valid_o,
    output lsu_pkg::axi_ar_t              ar_o,
    input  logic                          ar_ready_i,
    output logic                          aw_valid_o,
    output logic                          w_valid_o,
    output lsu_pkg::axi_w_t               w_o,
    input  logic                          aw_ready_i,
    input  logic                          w_ready_i,
    input  logic                          b_valid_i,
    input  logic                          r_valid_i,
    input  logic [lsu_pkg::DATA_W-1:0]    r_data_i,
    output lsu_pkg::lsu_wb_t              wb_o
);
    import lsu_pkg::*;

    lsu_req_t               req_head;
    logic                   req_head_valid;
    logic                   req_pop;
    logic                   req_full;
    lsu_trk_t               trk_entry;
    logic                   trk_push;
    lsu_trk_t               trk_head;
    logic                   trk_head_valid;
    logic                   trk_pop;
    logic                   trk_full;
    logic [STORE_CNT_W-1:0] stores_pending;

    lsu_fifo #(
        .payload_t (lsu_req_t),
        .DEPTH     (REQ_DEPTH)
    ) u_req_q (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (req_valid_i),
        .push_data_i  (req_i),
        .pop_i        (req_pop),
        .head_valid_o (req_head_valid),
        .head_o       (req_head),
        .full_o       (req_full)
    );

    lsu_issue u_issue (
        .clk              (clk),
        .rst_n            (rst_n),
        .head_valid_i     (req_head_valid),
        .head_i           (req_head),
        .pop_o            (req_pop),
        .trk_full_i       (trk_full),
        .trk_push_o       (trk_push),
        .trk_o            (trk_entry),
        .ar_valid_o       (ar_valid_o),
        .ar_o             (ar_o),
        .ar_ready_i       (ar_ready_i),
        .aw_valid_o       (aw_valid_o),
        .w_valid_o        (w_valid_o),
        .w_o              (w_o),
        .aw_ready_i       (aw_ready_i),
        .w_ready_i        (w_ready_i),
        .b_valid_i        (b_valid_i),
        .stores_pending_o (stores_pending)
    );

    lsu_fifo #(
        .payload_t (lsu_trk_t),
        .DEPTH     (TRK_DEPTH)
    ) u_trk_q (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (trk_push),
        .push_data_i  (trk_entry),
        .pop_i        (trk_pop),
        .head_valid_o (trk_head_valid),
        .head_o       (trk_head),
        .full_o       (trk_full)
    );

    lsu_load_align u_align (
        .trk_valid_i (trk_head_valid),
        .trk_i       (trk_head),
        .r_valid_i   (r_valid_i),
        .r_data_i    (r_data_i),
        .trk_pop_o   (trk_pop),
        .wb_o        (wb_o)
    );

    assign stall_o = req_full;

    // anything queued, in flight or waiting for a write response
    assign busy_o = req_head_valid || trk_head_valid || (stores_pending != '0);

endmodule

//--- run.sh
#!/bin/sh
# build the load/store unit testbench with Verilator, run it and scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_lsu -o sim_lsu \
    && ./obj_dir/sim_lsu +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- sources.f
lsu_pkg.sv
lsu_fifo.sv
lsu_issue.sv
lsu_load_align.sv
lsu_top.sv
lsu_sva.sv
tb_clkgen.sv
tb_lsu.sv

//--- tb_clkgen.sv
// testbench clock with period 100 and active-low power-on reset
module tb_clkgen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- tb_lsu.sv
// testbench top with the stimulus reader, bus slave memory model,
// write-back and write checks, timeout and result line
module tb_lsu;
    import lsu_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int STIM_FIELDS  = 7;
    localparam int STIM_LINES   = 32;
    localparam int MEM_WORDS    = 16;

    logic              clk, rst_n;
    logic              req_valid_i, stall_o, busy_o;
    lsu_req_t          req_i;
    logic              ar_valid_o, ar_ready_i;
    axi_ar_t           ar_o;
    logic              aw_valid_o, w_valid_o, aw_ready_i, w_ready_i, b_valid_i;
    axi_w_t            w_o;
    logic              r_valid_i;
    logic [DATA_W-1:0] r_data_i;
    lsu_wb_t           wb_o;

    logic [DATA_W-1:0] stim [STIM_FIELDS * STIM_LINES];
    logic [DATA_W-1:0] mem [MEM_WORDS];
    lsu_wb_t           exp_wb_q[$];
    axi_w_t            exp_w_q[$];
    int                r_due_q[$];
    logic [ADDR_W-1:0] r_addr_q[$];
    integer            seed;
    int                cyc, limit, stores_open, b_pend;
    int                wb_errs, wr_errs, other_errs;
    logic              aw_got, w_got, hold_ar, hold_used, stall_seen;

    tb_clkgen #(.RESET_CYCLES(RESET_CYCLES)) u_clkgen (.clk(clk), .rst_n(rst_n));

    lsu_top dut_i (.*);

    bind lsu_top lsu_sva u_sva (.*);

    task automatic check_wb(input lsu_wb_t got, input lsu_wb_t exp);
        if (got !== exp) begin
            wb_errs++;
            $display("ERR %0t wb_o exp rd=%0d data=%h id=%0d got rd=%0d data=%h id=%0d",
                     $time, exp.rd, exp.data, exp.commit_id, got.rd, got.data, got.commit_id);
        end
    endtask

    task automatic check_write(input axi_w_t got, input axi_w_t exp);
        if (got !== exp) begin
            wr_errs++;
            $display("ERR %0t w_o exp addr=%h data=%h strb=%h got addr=%h data=%h strb=%h",
                     $time, exp.addr, exp.data, exp.strb, got.addr, got.data, got.strb);
        end
    endtask

    // one-cycle request strobe entered and left on a falling edge
    task automatic send_req(input lsu_req_t req);
        while (stall_o) @(negedge clk);
        req_valid_i = 1'b1;
        req_i       = req;
        @(negedge clk);
        req_valid_i = 1'b0;
        if (!busy_o) begin
            other_errs++;
            $display("busy_o low at %0t right after a request was accepted", $time);
        end
    endtask

    // slave side ready patterns, write responses and in-order read beats
    always @(negedge clk) begin
        // the slave starts after the first rising edge
        if (cyc != 0) begin
            if (hold_ar && stall_o) begin
                stall_seen = 1'b1;
                hold_ar    = 1'b0;
            end
            ar_ready_i = !hold_ar && (($random(seed) & 3) != 0);
            aw_ready_i = ($random(seed) & 1) != 0;
            w_ready_i  = ($random(seed) & 1) != 0;
            if (b_pend != 0 && !busy_o) begin
                other_errs++;
                $display("busy_o low at %0t while a store response is outstanding", $time);
            end
            b_valid_i = (b_pend != 0);
            if (r_due_q.size() != 0 && r_due_q[0] <= cyc) begin
                r_valid_i = 1'b1;
                r_data_i  = mem[r_addr_q[0][5:2]];
                void'(r_due_q.pop_front());
                void'(r_addr_q.pop_front());
            end else begin
                r_valid_i = 1'b0;
                r_data_i  = '0;
            end
        end
    end

    // handshakes as seen by the DUT at the rising edge
    always @(posedge clk) begin
        lsu_wb_t exp_wb;
        axi_w_t  exp_w;
        cyc = cyc + 1;
        if (rst_n) begin
            // beat comes back 1 to 3 cycles after its address
            if (ar_valid_o && ar_ready_i) begin
                r_due_q.push_back(cyc + (($random(seed) & 255) % 3));
                r_addr_q.push_back(ar_o.addr);
            end
            if (aw_valid_o && aw_ready_i) begin
                aw_got = 1'b1;
            end
            if (w_valid_o && w_ready_i) begin
                if (exp_w_q.size() == 0) begin
                    other_errs++;
                    $display("write at %0t with no store outstanding", $time);
                end else begin
                    exp_w = exp_w_q.pop_front();
                    check_write(w_o, exp_w);
                end
                for (int b = 0; b < STRB_W; b++) begin
                    if (w_o.strb[b]) begin
                        mem[w_o.addr[5:2]][8*b +: 8] = w_o.data[8*b +: 8];
                    end
                end
                w_got = 1'b1;
            end
            if (aw_got && w_got) begin
                b_pend++;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            if (b_valid_i) begin
                b_pend--;
                stores_open--;
            end
            if (wb_o.valid) begin
                if (exp_wb_q.size() == 0) begin
                    other_errs++;
                    $display("write-back at %0t with no load outstanding", $time);
                end else begin
                    exp_wb = exp_wb_q.pop_front();
                    check_wb(wb_o, exp_wb);
                end
            end
        end
        if (cyc > limit) begin
            $display("timeout after %0d cycles with traffic still outstanding", cyc);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        lsu_req_t req;
        lsu_wb_t  exp_wb;
        axi_w_t   exp_w;
        int       base;
        int       n_req;
        seed        = 32'h2771_5cbe;
        req_valid_i = 1'b0;
        req_i       = '0;
        ar_ready_i  = 1'b0;
        aw_ready_i  = 1'b0;
        w_ready_i   = 1'b0;
        b_valid_i   = 1'b0;
        r_valid_i   = 1'b0;
        r_data_i    = '0;
        aw_got      = 1'b0;
        w_got       = 1'b0;
        hold_ar     = 1'b0;
        hold_used   = 1'b0;
        stall_seen  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i * 32'h0001_0203);
        end
        $readmemh("lsu_stimulus.txt", stim);
        n_req = 0;
        for (int i = 0; i < STIM_LINES && stim[i * STIM_FIELDS] != 'hf; i++) begin
            if (stim[i * STIM_FIELDS] < 6) begin
                n_req++;
            end
        end
        limit = n_req * 40 + RESET_CYCLES;

        @(posedge rst_n);
        @(negedge clk);
        if (busy_o || stall_o) begin
            other_errs++;
            $display("busy_o or stall_o high right after reset");
        end

        base = 0;
        while (base < STIM_FIELDS * STIM_LINES && stim[base] != 'hf) begin
            case (stim[base])
                7: mem[stim[base + 1][5:2]] = stim[base + 2];
                6: begin
                    // hold AR off until the request queue fills
                    @(posedge clk);
                    hold_ar   = 1'b1;
                    hold_used = 1'b1;
                    @(negedge clk);
                end
                default: begin
                    req.op        = lsu_op_e'(stim[base][2:0]);
                    req.addr      = stim[base + 1];
                    req.wdata     = stim[base + 2];
                    req.wstrb     = stim[base + 3][STRB_W-1:0];
                    req.rd        = stim[base + 4][REG_ADDR_W-1:0];
                    req.commit_id = stim[base + 5][COMMIT_ID_W-1:0];
                    if (req.op == LSU_SW) begin
                        exp_w.addr = req.addr;
                        exp_w.data = req.wdata;
                        exp_w.strb = req.wstrb;
                        exp_w_q.push_back(exp_w);
                        stores_open++;
                    end else begin
                        exp_wb.valid     = 1'b1;
                        exp_wb.rd        = req.rd;
                        exp_wb.data      = stim[base + 6];
                        exp_wb.commit_id = req.commit_id;
                        exp_wb_q.push_back(exp_wb);
                    end
                    send_req(req);
                end
            endcase
            base += STIM_FIELDS;
        end

        while (exp_wb_q.size() != 0 || stores_open != 0) @(negedge clk);
        if (busy_o) begin
            other_errs++;
            $display("busy_o still high after all traffic drained");
        end
        if (hold_used && !stall_seen) begin
            other_errs++;
            $display("stall_o never rose while ar_ready_i was held low");
        end
        $display("errors: wb %0d, write %0d, other %0d, assertion %0d",
                 wb_errs, wr_errs, other_errs, dut_i.u_sva.fail_count);
        if (wb_errs + wr_errs + other_errs + dut_i.u_sva.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
